// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = am_lock_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Test failures found
PASS_MSG = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; else echo "simulation PASSED"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
src/pcs_block_pkg.sv
src/am_pkg.sv
src/am_comparator.sv
src/am_timer.sv
src/bip_checker.sv
src/am_lock_fsm.sv
src/am_lock_module.sv
test/am_lock_tb.sv

// ==== src/am_comparator.sv ====
`default_nettype none
`timescale 1ns/100ps

module am_comparator
(
	input  wire pcs_block_pkg::coded_block_t i_block,
	input  wire am_pkg::lane_mask_t          i_match_mask,    // runtime lane enables
	output logic                             o_match,
	output am_pkg::lane_id_t                 o_lane
);

	logic [7:0]         pl_byte [0:7];    // payload split into bytes
	logic               ctrl_sh;
	am_pkg::am_value_t  am_value;
	am_pkg::lane_mask_t match_vector;     // one bit per lane

	always_comb
	begin
		for (int k = 0; k < 8; k++)
			pl_byte[k] = i_block[pcs_block_pkg::LEN_SH + 8*k +: 8];
		ctrl_sh  = (i_block[pcs_block_pkg::LEN_SH-1:0] == pcs_block_pkg::SH_CTRL);
		// skip bip3 (byte 3) and bip7 (byte 7)
		am_value = {pl_byte[0], pl_byte[1], pl_byte[2], pl_byte[4], pl_byte[5], pl_byte[6]};
		for (int i = 0; i < am_pkg::N_ALIGNER; i++)
			match_vector[i] = ctrl_sh && i_match_mask[i] && (am_value == am_pkg::AM_TABLE[i]);
		// markers are distinct so no block may hit two lanes
		assert ($onehot0(match_vector))
			else $error("am_comparator: block matches more than one lane marker");
	end

	// lowest lane wins, loop runs downward so low index overrides
	always_comb
	begin
		o_lane = '0;
		for (int i = am_pkg::N_ALIGNER - 1; i >= 0; i--)
		begin
			if (match_vector[i])
				o_lane = am_pkg::lane_id_t'(i);
		end
	end

	assign o_match = |match_vector;

endmodule

`default_nettype wire

// ==== src/am_lock_fsm.sv ====
`default_nettype none
`timescale 1ns/100ps

module am_lock_fsm
(
	input  wire                   i_clock,
	input  wire                   i_reset,
	input  wire                   i_valid,         // block in the input register
	input  wire                   i_match,         // some allowed lane matched
	input  wire am_pkg::lane_id_t i_match_lane,
	input  wire                   i_timer_done,    // expected marker position
	output logic                  o_am_strobe,     // replace and bip-restart this block
	output logic                  o_am_check,      // compare bip3 on this marker
	output logic                  o_timer_restart,
	output logic                  o_am_lock,
	output am_pkg::lane_id_t      o_lane_id        // captured lane
);

	am_pkg::am_lock_state_t         state;
	am_pkg::am_lock_state_t         next_state;
	logic [am_pkg::AM_MISS_W-1:0]   miss_count;    // consecutive missing markers
	logic                           lane_match;    // match on the captured lane

	always_comb
	begin
		next_state      = state;
		o_am_strobe     = 1'b0;
		o_am_check      = 1'b0;
		o_timer_restart = 1'b0;
		lane_match      = i_match && (i_match_lane == o_lane_id);
		if (i_valid)
		begin
			case (state)
				am_pkg::ST_SEARCH:
				begin
					if (i_match)    // any position counts while searching
					begin
						o_am_strobe     = 1'b1;
						o_timer_restart = 1'b1;
						next_state      = am_pkg::ST_CONFIRM;
					end
				end
				am_pkg::ST_CONFIRM:
				begin
					if (i_timer_done)
					begin
						if (lane_match)
						begin
							o_am_strobe     = 1'b1;
							o_am_check      = 1'b1;
							o_timer_restart = 1'b1;
							next_state      = am_pkg::ST_LOCKED;
						end
						else
							next_state = am_pkg::ST_SEARCH;    // wrong lane or no marker
					end
				end
				am_pkg::ST_LOCKED:
				begin
					if (i_timer_done)
					begin
						o_timer_restart = 1'b1;    // keep grid even on a miss
						if (lane_match)
						begin
							o_am_strobe = 1'b1;
							o_am_check  = 1'b1;
						end
						else if (int'(miss_count) == am_pkg::AM_BAD_LIMIT - 1)
							next_state = am_pkg::ST_SEARCH;
					end
				end
				default: next_state = am_pkg::ST_SEARCH;
			endcase
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state      <= am_pkg::ST_SEARCH;
			o_am_lock  <= 1'b0;
			o_lane_id  <= '0;
			miss_count <= '0;
		end
		else if (i_valid)
		begin
			state     <= next_state;
			o_am_lock <= (next_state == am_pkg::ST_LOCKED);
			if (state == am_pkg::ST_SEARCH && i_match)
				o_lane_id <= i_match_lane;    // lane taken from the first marker
			if (next_state != am_pkg::ST_LOCKED || (i_timer_done && lane_match))
				miss_count <= '0;
			else if (i_timer_done)
				miss_count <= miss_count + 1'b1;
		end
	end

	a_check_strobe: assert property (@(posedge i_clock) disable iff (i_reset)
		o_am_check |-> o_am_strobe);
	a_lock_state: assert property (@(posedge i_clock) disable iff (i_reset)
		o_am_lock |-> state == am_pkg::ST_LOCKED);

endmodule

`default_nettype wire

// ==== src/am_lock_module.sv ====
`default_nettype none
`timescale 1ns/100ps

module am_lock_module
#(
	parameter int P_PERIOD = am_pkg::AM_PERIOD    // blocks between markers
)
(
	input  wire                              i_clock,
	input  wire                              i_reset,
	input  wire                              i_enable,        // lane enable
	input  wire                              i_valid,         // new block strobe
	input  wire pcs_block_pkg::coded_block_t i_data,
	input  wire am_pkg::lane_mask_t          i_match_mask,
	output pcs_block_pkg::coded_block_t      o_data,
	output logic                             o_valid,
	output am_pkg::lane_id_t                 o_lane_id,
	output logic                             o_am_lock,
	output am_pkg::bip_count_t               o_bip_errors
);

	pcs_block_pkg::coded_block_t data_q;    // block under test
	logic                        valid_q;
	logic                        match;
	am_pkg::lane_id_t            match_lane;
	logic                        timer_done;
	logic                        timer_restart;
	logic                        am_strobe;
	logic                        am_check;

	always_ff @(posedge i_clock)
	begin
		if (i_valid && i_enable)
			data_q <= i_data;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			valid_q <= 1'b0;
		else
			valid_q <= i_valid && i_enable;    // one cycle per accepted block
	end

	am_comparator u_comparator
	(
		.i_block      (data_q),
		.i_match_mask (i_match_mask),
		.o_match      (match),
		.o_lane       (match_lane)
	);

	am_timer #(.P_PERIOD(P_PERIOD)) u_timer
	(
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_valid      (valid_q),
		.i_restart    (timer_restart),
		.o_timer_done (timer_done)
	);

	am_lock_fsm u_fsm
	(
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_valid         (valid_q),
		.i_match         (match),
		.i_match_lane    (match_lane),
		.i_timer_done    (timer_done),
		.o_am_strobe     (am_strobe),
		.o_am_check      (am_check),
		.o_timer_restart (timer_restart),
		.o_am_lock       (o_am_lock),
		.o_lane_id       (o_lane_id)
	);

	bip_checker u_bip_checker
	(
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_valid      (valid_q),
		.i_block      (data_q),
		.i_am_strobe  (am_strobe),
		.i_am_check   (am_check),
		.o_bip_errors (o_bip_errors)
	);

	// accepted markers leave as idle blocks
	assign o_data  = am_strobe ? pcs_block_pkg::CTRL_IDLE_BLOCK : data_q;
	assign o_valid = valid_q;

endmodule

`default_nettype wire

// ==== src/am_pkg.sv ====
`default_nettype none

package am_pkg;

	localparam int N_ALIGNER = 20;    // lanes per pcs
	localparam int LEN_AM    = 48;    // M0 M1 M2 M4 M5 M6, no bip bytes

	typedef logic [LEN_AM-1:0]    am_value_t;
	typedef logic [N_ALIGNER-1:0] lane_mask_t;    // bit i enables lane i
	typedef logic [4:0]           lane_id_t;
	typedef logic [7:0]           bip_t;
	typedef logic [15:0]          bip_count_t;

	// lane markers, index = lane number
	localparam am_value_t AM_TABLE [0:N_ALIGNER-1] = '{
		48'hC168213E97DE,
		48'h9D718E628E71,
		48'h594BE8A6B417,
		48'h4D957BB26A84,
		48'hF507090AF8F6,
		48'hDD14C222EB3D,
		48'h9A4A2665B5D9,
		48'h7B456684BA99,
		48'hA024765FDB89,
		48'h68C9FB973604,
		48'hFD6C99029366,
		48'hB99155466EAA,
		48'h5CB9B2A3464D,
		48'h1AF8BDE50742,
		48'h83C7CA7C3835,
		48'h3536CDCAC932,
		48'hC4314C3BCEB3,
		48'hADD6B7522948,
		48'h5F662AA099D5,
		48'hC0F0E53F0F1A
	};

	localparam int BIP3_BYTE = 3;    // payload byte carrying bip3

	localparam int AM_PERIOD    = 16384;    // marker plus 16383 blocks
	localparam int AM_BAD_LIMIT = 4;        // consecutive misses before unlock
	localparam int AM_MISS_W    = $clog2(AM_BAD_LIMIT);

	typedef enum logic [1:0]
	{
		ST_SEARCH,     // hunting any allowed marker
		ST_CONFIRM,    // waiting one period for the same lane
		ST_LOCKED
	} am_lock_state_t;

endpackage

`default_nettype wire

// ==== src/am_timer.sv ====
`default_nettype none
`timescale 1ns/100ps

module am_timer
#(
	parameter int P_PERIOD = am_pkg::AM_PERIOD    // blocks per marker period, >= 2
)
(
	input  wire  i_clock,
	input  wire  i_reset,
	input  wire  i_valid,      // one block in the input register
	input  wire  i_restart,    // marker seen, start a new period
	output logic o_timer_done
);

	localparam int           W    = $clog2(P_PERIOD);
	localparam logic [W-1:0] LAST = W'(P_PERIOD - 1);

	logic [W-1:0] count;    // blocks since the restarting one, minus one

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			count <= '0;
		else if (i_valid)
		begin
			if (i_restart || count == LAST)    // wrap keeps the grid when nobody restarts
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

	assign o_timer_done = (count == LAST);    // next marker due now

	a_count_range: assert property (@(posedge i_clock) disable iff (i_reset) count <= LAST);

endmodule

`default_nettype wire

// ==== src/bip_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

module bip_checker
(
	input  wire                         i_clock,
	input  wire                         i_reset,
	input  wire                         i_valid,
	input  wire pcs_block_pkg::coded_block_t i_block,
	input  wire                         i_am_strobe,    // block is an accepted marker
	input  wire                         i_am_check,     // marker at its expected slot
	output am_pkg::bip_count_t          o_bip_errors
);

	am_pkg::bip_t bip_acc;       // running parity since the last marker
	am_pkg::bip_t blk_parity;
	am_pkg::bip_t rx_bip3;       // parity byte carried by the marker

	// bit k of the bip covers payload bits with index k mod 8
	function automatic am_pkg::bip_t block_bip(input pcs_block_pkg::coded_block_t blk);
		am_pkg::bip_t p;
		p = '0;
		for (int j = 0; j < pcs_block_pkg::LEN_PAYLOAD; j++)
			p[j % 8] = p[j % 8] ^ blk[pcs_block_pkg::LEN_SH + j];
		p[3] = p[3] ^ blk[0];    // sync header folds into lanes 3 and 4
		p[4] = p[4] ^ blk[1];
		return p;
	endfunction

	assign blk_parity = block_bip(i_block);
	assign rx_bip3    = i_block[pcs_block_pkg::LEN_SH + 8*am_pkg::BIP3_BYTE +: 8];

	// parity accumulator
	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			if (i_am_strobe)
				bip_acc <= blk_parity;    // new window starts with the marker itself
			else
				bip_acc <= bip_acc ^ blk_parity;
		end
	end

	// mismatch counter, saturates at all ones
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_bip_errors <= '0;
		else if (i_valid && i_am_strobe && i_am_check)
		begin
			if (bip_acc != rx_bip3 && o_bip_errors != '1)
				o_bip_errors <= o_bip_errors + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/pcs_block_pkg.sv ====
`default_nettype none

package pcs_block_pkg;

	localparam int LEN_CODED_BLOCK = 66;    // 64b payload + 2b sync header
	localparam int LEN_SH          = 2;
	localparam int LEN_PAYLOAD     = LEN_CODED_BLOCK - LEN_SH;

	typedef logic [LEN_CODED_BLOCK-1:0] coded_block_t;    // sh in [1:0], byte k at 2+8k
	typedef logic [LEN_SH-1:0]          sync_header_t;

	localparam sync_header_t SH_CTRL = 2'b10;
	localparam sync_header_t SH_DATA = 2'b01;

	localparam logic [7:0] BLOCK_TYPE_IDLE = 8'h1E;    // all-control block type

	// idle block, block type in byte 0 and zero control codes
	localparam coded_block_t CTRL_IDLE_BLOCK =
		{{(LEN_PAYLOAD-8){1'b0}}, BLOCK_TYPE_IDLE, SH_CTRL};

endpackage

`default_nettype wire

// ==== test/am_lock_input.txt ====
# name enable valid mask sh payload | expected: sh payload lock lane bip_errors (dec)
# payload hex is byte7..byte0, markers read BIP7 M6 M5 M4 BIP3 M2 M1 M0
pass_data            1 1 fffff 1 9E3779B97F4A7C15 1 9E3779B97F4A7C15 0 0 0
data_sh_marker       1 1 fffff 1 D299BA842D66457B 1 D299BA842D66457B 0 0 0
mask_off             1 1 ffff7 2 A5846AB25A7B954D 2 A5846AB25A7B954D 0 0 0
mask_on              1 1 fffff 2 A5846AB25A7B954D 2 000000000000001E 0 3 0
fill                 1 1 fffff 1 0123456789ABCDEF 1 0123456789ABCDEF 0 3 0
fill                 1 1 fffff 1 FEDCBA9876543210 1 FEDCBA9876543210 0 3 0
fill                 1 1 fffff 1 0F1E2D3C4B5A6978 1 0F1E2D3C4B5A6978 0 3 0
confirm_wrong_lane   1 1 fffff 2 C317B4A63CE84B59 2 C317B4A63CE84B59 0 3 0
first_marker_bad_bip 1 1 fffff 2 FF99BA840066457B 2 000000000000001E 0 7 0
fill                 1 1 fffff 1 9E3779B97F4A7C15 1 9E3779B97F4A7C15 0 7 0
enable_low           0 1 fffff 1 0F1E2D3C4B5A6978 0 0000000000000000 0 7 0
fill                 1 1 fffff 1 0123456789ABCDEF 1 0123456789ABCDEF 0 7 0
fill                 1 1 fffff 1 FEDCBA9876543210 1 FEDCBA9876543210 0 7 0
confirm_lock         1 1 fffff 2 D299BA842D66457B 2 000000000000001E 1 7 0
fill                 1 1 fffff 1 0123456789ABCDEF 1 0123456789ABCDEF 1 7 0
fill                 1 1 fffff 1 9E3779B97F4A7C15 1 9E3779B97F4A7C15 1 7 0
fill                 1 1 fffff 1 FEDCBA9876543210 1 FEDCBA9876543210 1 7 0
miss_before_good     1 1 fffff 1 13579BDF02468ACE 1 13579BDF02468ACE 1 7 0
fill                 1 1 fffff 1 0F1E2D3C4B5A6978 1 0F1E2D3C4B5A6978 1 7 0
fill                 1 1 fffff 1 9E3779B97F4A7C15 1 9E3779B97F4A7C15 1 7 0
fill                 1 1 fffff 1 0123456789ABCDEF 1 0123456789ABCDEF 1 7 0
marker_bad_bip3      1 1 fffff 2 1899BA84E766457B 2 000000000000001E 1 7 1
fill                 1 1 fffff 1 FEDCBA9876543210 1 FEDCBA9876543210 1 7 1
fill                 1 1 fffff 1 0123456789ABCDEF 1 0123456789ABCDEF 1 7 1
fill                 1 1 fffff 1 9E3779B97F4A7C15 1 9E3779B97F4A7C15 1 7 1
miss_1_wrong_lane    1 1 fffff 2 A5846AB25A7B954D 2 A5846AB25A7B954D 1 7 1
fill                 1 1 fffff 1 0F1E2D3C4B5A6978 1 0F1E2D3C4B5A6978 1 7 1
fill                 1 1 fffff 1 13579BDF02468ACE 1 13579BDF02468ACE 1 7 1
fill                 1 1 fffff 1 0123456789ABCDEF 1 0123456789ABCDEF 1 7 1
miss_2               1 1 fffff 1 FEDCBA9876543210 1 FEDCBA9876543210 1 7 1
fill                 1 1 fffff 1 9E3779B97F4A7C15 1 9E3779B97F4A7C15 1 7 1
fill                 1 1 fffff 1 0F1E2D3C4B5A6978 1 0F1E2D3C4B5A6978 1 7 1
fill                 1 1 fffff 1 13579BDF02468ACE 1 13579BDF02468ACE 1 7 1
miss_3_keep_lock     1 1 fffff 1 0123456789ABCDEF 1 0123456789ABCDEF 1 7 1
fill                 1 1 fffff 1 FEDCBA9876543210 1 FEDCBA9876543210 1 7 1
fill                 1 1 fffff 1 9E3779B97F4A7C15 1 9E3779B97F4A7C15 1 7 1
fill                 1 1 fffff 1 0F1E2D3C4B5A6978 1 0F1E2D3C4B5A6978 1 7 1
miss_4_lose_lock     1 1 fffff 1 13579BDF02468ACE 1 13579BDF02468ACE 0 7 1

// ==== test/am_lock_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module am_lock_tb;

	localparam int    VALID_WAIT = 20;    // cycles allowed for o_valid
	localparam string INPUT_FILE = "test/am_lock_input.txt";

	logic                        clock = 1'b0;
	logic                        reset;
	logic                        enable;
	logic                        valid;
	pcs_block_pkg::coded_block_t data_in;
	am_pkg::lane_mask_t          match_mask;
	pcs_block_pkg::coded_block_t data_out;
	logic                        valid_out;
	am_pkg::lane_id_t            lane_id;
	logic                        am_lock;
	am_pkg::bip_count_t          bip_errors;

	logic [31:0] lfsr = 32'hb89f5bac;
	int          checks = 0;
	int          mismatches = 0;
	int          failures = 0;    // timeouts, bad stimulus lines

	am_lock_module #(.P_PERIOD(4)) dut0
	(
		.i_clock      (clock),
		.i_reset      (reset),
		.i_enable     (enable),
		.i_valid      (valid),
		.i_data       (data_in),
		.i_match_mask (match_mask),
		.o_data       (data_out),
		.o_valid      (valid_out),
		.o_lane_id    (lane_id),
		.o_am_lock    (am_lock),
		.o_bip_errors (bip_errors)
	);

	always #4 clock = ~clock;    // 8 ns period

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// junk for idle cycles
	task automatic random_block(output pcs_block_pkg::coded_block_t blk);
		for (int i = 0; i < pcs_block_pkg::LEN_CODED_BLOCK; i++)
		begin
			lfsr   = lfsr_next(lfsr);    // one step per bit taken
			blk[i] = lfsr[0];
		end
	endtask

	task automatic check_value(input string name, input string what,
		input logic [65:0] expected, input logic [65:0] actual);
		checks++;
		if (actual !== expected)
		begin
			mismatches++;
			$display("Fail %s %s: expected %h, actual %h", name, what, expected, actual);
		end
	endtask

	// block cycle and idle cycle then checks
	task automatic run_line(input string text);
		string                       tag;
		logic                        l_enable;
		logic                        l_valid;
		am_pkg::lane_mask_t          l_mask;
		pcs_block_pkg::sync_header_t l_sh;
		logic [63:0]                 l_payload;
		pcs_block_pkg::sync_header_t x_sh;
		logic [63:0]                 x_payload;
		logic                        x_lock;
		am_pkg::lane_id_t            x_lane;
		am_pkg::bip_count_t          x_errors;
		pcs_block_pkg::coded_block_t idle_data;
		int                          fields;
		int                          wait_cycles;
		fields = $sscanf(text, "%s %h %h %h %h %h %h %h %h %d %d", tag, l_enable, l_valid,
			l_mask, l_sh, l_payload, x_sh, x_payload, x_lock, x_lane, x_errors);
		if (fields != 11)
		begin
			$display("stimulus line could not be parsed: %s", text);
			failures++;
		end
		else
		begin
			enable     = l_enable;
			valid      = l_valid;
			match_mask = l_mask;
			data_in    = {l_payload, l_sh};
			@(posedge clock);
			#1;
			random_block(idle_data);
			valid   = 1'b0;
			enable  = 1'b1;
			data_in = idle_data;    // must be ignored
			if (l_enable && l_valid)
			begin
				wait_cycles = 0;
				while (valid_out !== 1'b1 && wait_cycles < VALID_WAIT)
				begin
					@(posedge clock);
					#1;
					wait_cycles++;
				end
				if (valid_out !== 1'b1)
				begin
					$display("%s: o_valid did not rise within %0d cycles", tag, VALID_WAIT);
					failures++;
				end
				else
					check_value(tag, "o_data", {x_payload, x_sh}, data_out);
			end
			else
				check_value(tag, "o_valid", '0, 66'(valid_out));    // dropped block
			@(posedge clock);
			#1;
			check_value(tag, "o_valid low", '0, 66'(valid_out));    // one cycle only
			check_value(tag, "o_am_lock", 66'(x_lock), 66'(am_lock));
			check_value(tag, "o_lane_id", 66'(x_lane), 66'(lane_id));
			check_value(tag, "o_bip_errors", 66'(x_errors), 66'(bip_errors));
		end
	endtask

	initial
	begin
		int    fd;
		int    code;
		string text;
		reset      = 1'b1;
		enable     = 1'b0;
		valid      = 1'b0;
		data_in    = '0;
		match_mask = '0;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0)
		begin
			$display("cannot open stimulus file %s", INPUT_FILE);
			failures++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				code = $fgets(text, fd);
				if (code > 0 && text.len() > 1 && text.getc(0) != "#")    // skip comments
					run_line(text);
			end
			$fclose(fd);
		end
		$display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire
